// ==== axil_pause.sv ====
`timescale 1ns/10ps

module axil_pause #(
    parameter int ADDR_WIDTH = axil_pause_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH = axil_pause_pkg::DATA_WIDTH_DEF,
    parameter int MAX_TRANS  = 7
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    pause_req,
    output logic                    pause_ack,

    input  logic [ADDR_WIDTH-1:0]   s_awaddr,
    input  logic [2:0]              s_awprot,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [DATA_WIDTH-1:0]   s_wdata,
    input  logic [DATA_WIDTH/8-1:0] s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [ADDR_WIDTH-1:0]   s_araddr,
    input  logic [2:0]              s_arprot,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [DATA_WIDTH-1:0]   s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,

    output logic [ADDR_WIDTH-1:0]   m_awaddr,
    output logic [2:0]              m_awprot,
    output logic                    m_awvalid,
    input  logic                    m_awready,
    output logic [DATA_WIDTH-1:0]   m_wdata,
    output logic [DATA_WIDTH/8-1:0] m_wstrb,
    output logic                    m_wvalid,
    input  logic                    m_wready,
    input  logic [1:0]              m_bresp,
    input  logic                    m_bvalid,
    output logic                    m_bready,
    output logic [ADDR_WIDTH-1:0]   m_araddr,
    output logic [2:0]              m_arprot,
    output logic                    m_arvalid,
    input  logic                    m_arready,
    input  logic [DATA_WIDTH-1:0]   m_rdata,
    input  logic [1:0]              m_rresp,
    input  logic                    m_rvalid,
    output logic                    m_rready
);

    localparam int CNT_W = $clog2(MAX_TRANS + 1);

    logic             awfire;
    logic             wfire;
    logic             bfire;
    logic             arfire;
    logic             rfire;
    logic [CNT_W-1:0] aw_pend;
    logic [CNT_W-1:0] w_pend;
    logic             quiescent;
    logic             wr_full;
    logic             rd_full;
    logic             block;

    // Responses are never gated.
    assign s_bresp  = m_bresp;
    assign s_bvalid = m_bvalid;
    assign m_bready = s_bready;
    assign s_rdata  = m_rdata;
    assign s_rresp  = m_rresp;
    assign s_rvalid = m_rvalid;
    assign m_rready = s_rready;

    assign awfire = m_awvalid && m_awready;
    assign wfire  = m_wvalid && m_wready;
    assign bfire  = m_bvalid && m_bready;
    assign arfire = m_arvalid && m_arready;
    assign rfire  = m_rvalid && m_rready;

    axil_pause_gate #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .MAX_TRANS  (MAX_TRANS)
    ) axil_pause_gate_inst (.*);

    axil_pause_tracker #(
        .MAX_TRANS (MAX_TRANS)
    ) axil_pause_tracker_inst (
        .rd_pend (),
        .*
    );

    axil_pause_ctrl axil_pause_ctrl_inst (.*);

    paused_no_addr_a: assert property (@(posedge seq) disable iff (!rst_n)
        pause_ack |-> !m_awvalid && !m_arvalid)
        else $error("address phase issued downstream while paused");

endmodule

// ==== axil_pause_ctrl.sv ====
`timescale 1ns/10ps

module axil_pause_ctrl (
    input  logic seq,
    input  logic rst_n,
    input  logic pause_req,
    input  logic quiescent,
    output logic block,
    output logic pause_ack
);
    import axil_pause_pkg::*;

    pause_state_e state;
    pause_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (pause_req) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: begin
                if (!pause_req) begin
                    state_next = RUN; // Request withdrawn before drain finished.
                end else if (quiescent) begin
                    state_next = PAUSED;
                end
            end
            PAUSED: begin
                if (!pause_req) begin
                    state_next = RUN;
                end
            end
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

    assign block     = (state != RUN);
    assign pause_ack = (state == PAUSED);

    ack_idle_a: assert property (@(posedge seq) disable iff (!rst_n)
        pause_ack |-> quiescent)
        else $error("pause_ack high with transactions in flight");

endmodule

// ==== axil_pause_gate.sv ====
`timescale 1ns/10ps

module axil_pause_gate #(
    parameter int ADDR_WIDTH = axil_pause_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH = axil_pause_pkg::DATA_WIDTH_DEF,
    parameter int MAX_TRANS  = 7
) (
    input  logic                             block,
    input  logic                             wr_full,
    input  logic                             rd_full,
    input  logic [$clog2(MAX_TRANS+1)-1:0]   aw_pend,
    input  logic [$clog2(MAX_TRANS+1)-1:0]   w_pend,

    input  logic [ADDR_WIDTH-1:0]            s_awaddr,
    input  logic [2:0]                       s_awprot,
    input  logic                             s_awvalid,
    output logic                             s_awready,
    input  logic [DATA_WIDTH-1:0]            s_wdata,
    input  logic [DATA_WIDTH/8-1:0]          s_wstrb,
    input  logic                             s_wvalid,
    output logic                             s_wready,
    input  logic [ADDR_WIDTH-1:0]            s_araddr,
    input  logic [2:0]                       s_arprot,
    input  logic                             s_arvalid,
    output logic                             s_arready,

    output logic [ADDR_WIDTH-1:0]            m_awaddr,
    output logic [2:0]                       m_awprot,
    output logic                             m_awvalid,
    input  logic                             m_awready,
    output logic [DATA_WIDTH-1:0]            m_wdata,
    output logic [DATA_WIDTH/8-1:0]          m_wstrb,
    output logic                             m_wvalid,
    input  logic                             m_wready,
    output logic [ADDR_WIDTH-1:0]            m_araddr,
    output logic [2:0]                       m_arprot,
    output logic                             m_arvalid,
    input  logic                             m_arready
);

    localparam int CNT_W = $clog2(MAX_TRANS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MAX_TRANS);

    logic aw_open;
    logic w_open;
    logic ar_open;

    assign aw_open = !block && !wr_full;
    assign ar_open = !block && !rd_full;
    // While draining, W only for addresses already accepted.
    assign w_open  = (w_pend < CNT_MAX) && (!block || (aw_pend > w_pend));

    assign m_awaddr  = s_awaddr;
    assign m_awprot  = s_awprot;
    assign m_awvalid = s_awvalid && aw_open;
    assign s_awready = m_awready && aw_open;

    assign m_wdata   = s_wdata;
    assign m_wstrb   = s_wstrb;
    assign m_wvalid  = s_wvalid && w_open;
    assign s_wready  = m_wready && w_open;

    assign m_araddr  = s_araddr;
    assign m_arprot  = s_arprot;
    assign m_arvalid = s_arvalid && ar_open;
    assign s_arready = m_arready && ar_open;

endmodule

// ==== axil_pause_pkg.sv ====
package axil_pause_pkg;

    // Default bus widths for every module header.
    localparam int ADDR_WIDTH_DEF = 32;
    localparam int DATA_WIDTH_DEF = 32;

    // AXI4-Lite response codes used by the register target.
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axi_resp_e;

    // Pause control states.
    typedef enum logic [1:0] {
        RUN    = 2'd0, // Traffic flows freely.
        DRAIN  = 2'd1, // New address phases held, waiting for completions.
        PAUSED = 2'd2  // Nothing in flight, acknowledge raised.
    } pause_state_e;

endpackage

// ==== axil_pause_sys.sv ====
`timescale 1ns/10ps

module axil_pause_sys #(
    parameter int ADDR_WIDTH = axil_pause_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH = axil_pause_pkg::DATA_WIDTH_DEF,
    parameter int MAX_TRANS  = 7,
    parameter int REG_COUNT  = 16
) (
    input  logic                    seq,
    input  logic                    rst_n,
    input  logic                    pause_req,
    output logic                    pause_ack,

    input  logic [ADDR_WIDTH-1:0]   s_awaddr,
    input  logic [2:0]              s_awprot,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [DATA_WIDTH-1:0]   s_wdata,
    input  logic [DATA_WIDTH/8-1:0] s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [ADDR_WIDTH-1:0]   s_araddr,
    input  logic [2:0]              s_arprot,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [DATA_WIDTH-1:0]   s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready
);

    logic [ADDR_WIDTH-1:0]   m_awaddr;
    logic [2:0]              m_awprot;
    logic                    m_awvalid;
    logic                    m_awready;
    logic [DATA_WIDTH-1:0]   m_wdata;
    logic [DATA_WIDTH/8-1:0] m_wstrb;
    logic                    m_wvalid;
    logic                    m_wready;
    logic [1:0]              m_bresp;
    logic                    m_bvalid;
    logic                    m_bready;
    logic [ADDR_WIDTH-1:0]   m_araddr;
    logic [2:0]              m_arprot;
    logic                    m_arvalid;
    logic                    m_arready;
    logic [DATA_WIDTH-1:0]   m_rdata;
    logic [1:0]              m_rresp;
    logic                    m_rvalid;
    logic                    m_rready;

    axil_pause #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .MAX_TRANS  (MAX_TRANS)
    ) axil_pause_inst (.*);

    axil_reg_target #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .REG_COUNT  (REG_COUNT)
    ) axil_reg_target_inst (.*);

endmodule

// ==== axil_pause_tracker.sv ====
`timescale 1ns/10ps

module axil_pause_tracker #(
    parameter int MAX_TRANS = 7
) (
    input  logic                           seq,
    input  logic                           rst_n,
    input  logic                           awfire,
    input  logic                           wfire,
    input  logic                           bfire,
    input  logic                           arfire,
    input  logic                           rfire,
    output logic [$clog2(MAX_TRANS+1)-1:0] aw_pend,
    output logic [$clog2(MAX_TRANS+1)-1:0] w_pend,
    output logic [$clog2(MAX_TRANS+1)-1:0] rd_pend,
    output logic                           quiescent,
    output logic                           wr_full,
    output logic                           rd_full
);

    localparam int CNT_W = $clog2(MAX_TRANS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MAX_TRANS);

    function automatic logic [CNT_W-1:0] step(
        input logic [CNT_W-1:0] cnt,
        input logic             inc,
        input logic             dec
    );
        logic [CNT_W-1:0] res;
        res = cnt;
        if (inc && !dec) begin
            res = cnt + CNT_W'(1);
        end else if (dec && !inc) begin
            res = cnt - CNT_W'(1);
        end
        return res;
    endfunction

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            aw_pend <= '0;
            w_pend  <= '0;
            rd_pend <= '0;
        end else begin
            aw_pend <= step(aw_pend, awfire, bfire); // One B retires an AW and a W.
            w_pend  <= step(w_pend, wfire, bfire);
            rd_pend <= step(rd_pend, arfire, rfire);
        end
    end

    assign quiescent = (aw_pend == '0) && (w_pend == '0) && (rd_pend == '0);
    assign wr_full   = (aw_pend == CNT_MAX);
    assign rd_full   = (rd_pend == CNT_MAX);

    no_overflow_a: assert property (@(posedge seq) disable iff (!rst_n)
        !(awfire && !bfire && aw_pend == CNT_MAX) &&
        !(wfire && !bfire && w_pend == CNT_MAX) &&
        !(arfire && !rfire && rd_pend == CNT_MAX))
        else $error("outstanding counter pushed past MAX_TRANS");

    b_underflow_a: assert property (@(posedge seq) disable iff (!rst_n)
        bfire |-> (aw_pend != '0) && (w_pend != '0))
        else $error("B response with no write outstanding");

    r_underflow_a: assert property (@(posedge seq) disable iff (!rst_n)
        rfire |-> (rd_pend != '0))
        else $error("R response with no read outstanding");

endmodule

// ==== axil_reg_target.sv ====
`timescale 1ns/10ps

module axil_reg_target #(
    parameter int ADDR_WIDTH = axil_pause_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH = axil_pause_pkg::DATA_WIDTH_DEF,
    parameter int REG_COUNT  = 16
) (
    input  logic                    seq,
    input  logic                    rst_n,

    input  logic [ADDR_WIDTH-1:0]   m_awaddr,
    input  logic [2:0]              m_awprot,
    input  logic                    m_awvalid,
    output logic                    m_awready,
    input  logic [DATA_WIDTH-1:0]   m_wdata,
    input  logic [DATA_WIDTH/8-1:0] m_wstrb,
    input  logic                    m_wvalid,
    output logic                    m_wready,
    output logic [1:0]              m_bresp,
    output logic                    m_bvalid,
    input  logic                    m_bready,
    input  logic [ADDR_WIDTH-1:0]   m_araddr,
    input  logic [2:0]              m_arprot,
    input  logic                    m_arvalid,
    output logic                    m_arready,
    output logic [DATA_WIDTH-1:0]   m_rdata,
    output logic [1:0]              m_rresp,
    output logic                    m_rvalid,
    input  logic                    m_rready
);
    import axil_pause_pkg::*;

    localparam int STRB_W   = DATA_WIDTH / 8;
    localparam int ADDR_LSB = $clog2(STRB_W);
    localparam int WORD_W   = ADDR_WIDTH - ADDR_LSB;
    localparam int IDX_W    = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];
    logic [WORD_W-1:0]     aw_word;
    logic [WORD_W-1:0]     ar_word;
    logic [IDX_W-1:0]      aw_idx;
    logic [IDX_W-1:0]      ar_idx;
    logic                  aw_hit;
    logic                  ar_hit;
    logic                  wr_fire;
    logic                  rd_fire;

    assign aw_word = m_awaddr[ADDR_WIDTH-1:ADDR_LSB];
    assign ar_word = m_araddr[ADDR_WIDTH-1:ADDR_LSB];
    assign aw_idx  = aw_word[IDX_W-1:0];
    assign ar_idx  = ar_word[IDX_W-1:0];
    assign aw_hit  = (aw_word < WORD_W'(REG_COUNT));
    assign ar_hit  = (ar_word < WORD_W'(REG_COUNT));

    // AW and W are taken together, one write at a time.
    assign m_awready = m_awvalid && m_wvalid && !m_bvalid;
    assign m_wready  = m_awready;
    assign wr_fire   = m_awready;

    assign m_arready = !m_rvalid;
    assign rd_fire   = m_arvalid && m_arready;

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire && aw_hit) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (m_wstrb[b]) begin
                    regs[aw_idx][8*b +: 8] <= m_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            m_bvalid <= 1'b0;
            m_rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                m_bvalid <= 1'b1;
            end else if (m_bready) begin
                m_bvalid <= 1'b0;
            end
            if (rd_fire) begin
                m_rvalid <= 1'b1;
            end else if (m_rready) begin
                m_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (wr_fire) begin
            m_bresp <= aw_hit ? OKAY : SLVERR;
        end
        if (rd_fire) begin
            m_rdata <= ar_hit ? regs[ar_idx] : '0; // Out of range reads as zero.
            m_rresp <= ar_hit ? OKAY : SLVERR;
        end
    end

endmodule

// ==== flist.f ====
axil_pause_pkg.sv
axil_pause_gate.sv
axil_pause_tracker.sv
axil_pause_ctrl.sv
axil_pause.sv
axil_reg_target.sv
axil_pause_sys.sv
tb_axil_pause_sys.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_axil_pause_sys \
    -f flist.f \
    -o sim_tb_axil_pause_sys

./obj_dir/sim_tb_axil_pause_sys | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== tb_axil_pause_sys.sv ====
`timescale 1ns/10ps

module tb_axil_pause_sys;
    import axil_pause_pkg::*;

    localparam int REG_COUNT = 16;
    localparam int BOUND     = 50; // Cycle limit for one handshake and its response.

    logic        seq;
    logic        rst_n;
    logic        pause_req;
    logic        pause_ack;
    logic [31:0] s_awaddr;
    logic [31:0] s_wdata;
    logic [31:0] s_araddr;
    logic [31:0] s_rdata;
    logic [2:0]  s_awprot;
    logic [2:0]  s_arprot;
    logic [3:0]  s_wstrb;
    logic [1:0]  s_bresp;
    logic [1:0]  s_rresp;
    logic        s_awvalid;
    logic        s_awready;
    logic        s_wvalid;
    logic        s_wready;
    logic        s_bvalid;
    logic        s_bready;
    logic        s_arvalid;
    logic        s_arready;
    logic        s_rvalid;
    logic        s_rready;

    logic [31:0] model [REG_COUNT];
    int          errors;

    axil_pause_sys #(
        .MAX_TRANS (7),
        .REG_COUNT (REG_COUNT)
    ) axil_pause_sys_inst (.*);

    initial begin
        seq = 1'b0;
        forever #4 seq = ~seq;
    end

    initial begin
        #200000;
        $display("Watchdog expired before the test sequence finished");
        $display("TESTS FAILED");
        $finish;
    end

    // No address phase may be accepted upstream while paused.
    always @(negedge seq) begin
        if (rst_n && pause_ack && ((s_awvalid && s_awready) || (s_arvalid && s_arready))) begin
            $display("Address handshake accepted while pause_ack was high at %0t", $time);
            errors++;
        end
    end

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Tasks below start and end at a falling edge, where outputs are sampled.
    task automatic start_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        @(posedge seq);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= strb;
        s_wvalid  <= 1'b1;
        @(negedge seq);
    endtask

    task automatic finish_write(output logic [1:0] bresp);
        int   cyc;
        logic aw_hs;
        logic w_hs;
        cyc   = 0;
        bresp = 2'bxx;
        while ((s_awvalid || s_wvalid) && cyc < BOUND) begin
            aw_hs = s_awvalid && s_awready;
            w_hs  = s_wvalid && s_wready;
            @(posedge seq);
            if (aw_hs) begin
                s_awvalid <= 1'b0;
            end
            if (w_hs) begin
                s_wvalid <= 1'b0;
            end
            @(negedge seq);
            cyc++;
        end
        while (!s_bvalid && cyc < BOUND) begin
            @(negedge seq);
            cyc++;
        end
        if (cyc >= BOUND) begin
            $display("Write to %h hung without handshake or response", s_awaddr);
            errors++;
        end else begin
            bresp = s_bresp;
            @(negedge seq); // B completes on the edge in between.
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] bresp);
        start_write(addr, data, strb);
        finish_write(bresp);
    endtask

    task automatic complete_ar(input logic [31:0] addr);
        int cyc;
        cyc = 0;
        while (s_arvalid && cyc < BOUND) begin
            if (s_arready) begin
                @(posedge seq);
                s_arvalid <= 1'b0;
            end
            @(negedge seq);
            cyc++;
        end
        if (s_arvalid) begin
            $display("Read address %h was never accepted", addr);
            errors++;
        end
    endtask

    task automatic send_ar(input logic [31:0] addr);
        @(posedge seq);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        @(negedge seq);
        complete_ar(addr);
    endtask

    task automatic take_r(output logic [31:0] data, output logic [1:0] rresp);
        int cyc;
        cyc = 0;
        while (!(s_rvalid && s_rready) && cyc < BOUND) begin
            @(negedge seq);
            cyc++;
        end
        data  = s_rdata;
        rresp = s_rresp;
        if (cyc >= BOUND) begin
            $display("Read data never arrived");
            errors++;
        end else begin
            @(negedge seq);
        end
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] rresp);
        send_ar(addr);
        take_r(data, rresp);
    endtask

    task automatic set_pause(input logic val);
        @(posedge seq);
        pause_req <= val;
        @(negedge seq);
    endtask

    task automatic wait_ack(input logic val, input int limit, input string name);
        int cyc;
        cyc = 0;
        while (pause_ack !== val && cyc < limit) begin
            @(negedge seq);
            cyc++;
        end
        if (pause_ack !== val) begin
            $display("%s: pause_ack did not reach %0b within %0d cycles", name, val, limit);
            errors++;
        end
    endtask

    task automatic write_read();
        logic [31:0] data;
        logic [1:0]  resp;
        logic [3:0]  strb;
        for (int i = 0; i < 12; i++) begin
            data = $urandom;
            strb = (i < 6) ? 4'hf : 4'(i * 5); // Second pass merges partial bytes.
            axi_write(32'((i % 6) * 4), data, strb, resp);
            model[i % 6] = merge(model[i % 6], data, strb);
            compare("write_read bresp", 32'(OKAY), 32'(resp));
        end
        for (int i = 0; i < 6; i++) begin
            axi_read(32'(i * 4), data, resp);
            compare("write_read rdata", model[i], data);
            compare("write_read rresp", 32'(OKAY), 32'(resp));
        end
    endtask

    task automatic out_of_range();
        logic [31:0] data;
        logic [1:0]  resp;
        int          idx [3] = '{REG_COUNT, REG_COUNT + 1, 1000};
        foreach (idx[k]) begin
            axi_write(32'(idx[k] * 4), 32'hdead_beef, 4'hf, resp);
            compare("out_of_range bresp", 32'(SLVERR), 32'(resp));
            axi_read(32'(idx[k] * 4), data, resp);
            compare("out_of_range rdata", 32'h0, data);
            compare("out_of_range rresp", 32'(SLVERR), 32'(resp));
        end
        axi_read(32'h0, data, resp);
        compare("out_of_range reg0", model[0], data);
    endtask

    task automatic idle_pause();
        logic [31:0] data;
        logic [1:0]  resp;
        set_pause(1'b1);
        wait_ack(1'b1, 4, "idle_pause");
        data = $urandom;
        start_write(32'h8, data, 4'hf);
        for (int c = 0; c < 20; c++) begin
            compare("idle_pause awready", 32'h0, 32'(s_awready));
            compare("idle_pause pause_ack", 32'h1, 32'(pause_ack));
            @(negedge seq);
        end
        set_pause(1'b0);
        wait_ack(1'b0, 2, "idle_pause");
        finish_write(resp);
        model[2] = data;
        compare("idle_pause bresp", 32'(OKAY), 32'(resp));
        axi_read(32'h8, data, resp);
        compare("idle_pause rdata", model[2], data);
    endtask

    task automatic drain_read();
        logic [31:0] data;
        logic [1:0]  resp;
        @(posedge seq);
        s_rready <= 1'b0;
        @(negedge seq);
        send_ar(32'hc);
        set_pause(1'b1);
        for (int c = 0; c < 10; c++) begin
            compare("drain_read pause_ack", 32'h0, 32'(pause_ack));
            @(negedge seq);
        end
        @(posedge seq);
        s_rready <= 1'b1;
        @(negedge seq);
        take_r(data, resp);
        wait_ack(1'b1, 4, "drain_read");
        compare("drain_read rdata", model[3], data);
        compare("drain_read rresp", 32'(OKAY), 32'(resp));
        set_pause(1'b0);
        wait_ack(1'b0, 2, "drain_read");
    endtask

    task automatic random_traffic();
        logic [31:0] data;
        logic [1:0]  resp;
        logic [3:0]  strb;
        int          idx;
        for (int n = 0; n < 200; n++) begin
            idx = $urandom % REG_COUNT;
            if ($urandom % 2 == 0) begin
                data = $urandom;
                strb = 4'($urandom);
                axi_write(32'(idx * 4), data, strb, resp);
                model[idx] = merge(model[idx], data, strb);
                compare("random_traffic bresp", 32'(OKAY), 32'(resp));
            end else begin
                axi_read(32'(idx * 4), data, resp);
                compare("random_traffic rdata", model[idx], data);
                compare("random_traffic rresp", 32'(OKAY), 32'(resp));
            end
            if ($urandom % 8 == 0) begin
                set_pause(1'b1);
                wait_ack(1'b1, 8, "random_traffic");
                idx = $urandom % REG_COUNT;
                @(posedge seq);
                s_araddr  <= 32'(idx * 4);
                s_arvalid <= 1'b1; // Held back until the pause ends.
                @(negedge seq);
                repeat ($urandom % 16) @(negedge seq);
                set_pause(1'b0);
                wait_ack(1'b0, 2, "random_traffic");
                complete_ar(32'(idx * 4));
                take_r(data, resp);
                compare("random_traffic paused rdata", model[idx], data);
                compare("random_traffic paused rresp", 32'(OKAY), 32'(resp));
            end
        end
    endtask

    initial begin
        void'($urandom(32'h7981));
        errors    = 0;
        rst_n     = 1'b0;
        pause_req = 1'b0;
        s_awaddr  = '0;
        s_awprot  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1; // Responses accepted at once unless a test holds them.
        s_araddr  = '0;
        s_arprot  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (2) @(posedge seq);
        rst_n <= 1'b1;
        @(negedge seq);
        write_read();
        out_of_range();
        idle_pause();
        drain_read();
        random_traffic();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
